// ==== logic/agcTypesPkg.sv ====
// AGC datapath types
package agcTypesPkg;

    // measured peak level and the loop setpoint share one scale.
    typedef logic [7:0] level_t;

    // lead gain shift, where 7 is a gain of one.
    typedef logic [4:0] shift_t;

    // integrator, limits and lead error.
    // Gain is fixed point with 28 fraction bits, so 32'h1000_0000 is unity.
    typedef logic [31:0] loopWord_t;

    // register byte address on the microprocessor bus.
    typedef logic [12:0] regAddr_t;

    // bus read and write data.
    typedef logic [31:0] busWord_t;

    // samples per level measurement block.
    typedef logic [7:0] blockLen_t;

endpackage

// ==== logic/agcRegMapPkg.sv ====
// AGC register map
package agcRegMapPkg;

    import agcTypesPkg::*;

    localparam regAddr_t ctrlAddr       = 13'h000; // setpoint, error controls and gain shifts.
    localparam regAddr_t upperAddr      = 13'h004; // upper integrator limit.
    localparam regAddr_t lowerAddr      = 13'h008; // lower integrator limit.
    localparam regAddr_t integratorAddr = 13'h00C; // live integrator, read only.
    localparam regAddr_t blockAddr      = 13'h010; // block length in the low byte.

    // Field positions inside the control register.
    localparam int setpointLsb = 0;
    localparam int invertBit   = 8;
    localparam int zeroBit     = 9;
    localparam int posGainLsb  = 16;
    localparam int negGainLsb  = 24;

    localparam busWord_t ctrlMask = 32'h1F1F_03FF; // bits that exist in the control register.

    // setpoint 0x40, both shifts 8, invert and zero clear.
    localparam busWord_t  ctrlReset       = 32'h0808_0040;
    localparam loopWord_t upperReset      = 32'h4000_0000;
    localparam loopWord_t lowerReset      = 32'h0100_0000;
    localparam loopWord_t integratorReset = 32'h1000_0000; // unity gain.
    localparam blockLen_t blockLenReset   = 8'd16;

endpackage

// ==== logic/agcCtrlIf.sv ====
// AGC loop control interface
`timescale 1ns/1ps

interface agcCtrlIf import agcTypesPkg::*; ();

    level_t    setpoint;
    logic      invertError;
    logic      zeroError;
    shift_t    posErrorGain;
    shift_t    negErrorGain;
    loopWord_t upperLimit;
    loopWord_t lowerLimit;
    loopWord_t integrator;  // runs back from the filter for readback.

    modport regs (
        output setpoint, invertError, zeroError, posErrorGain, negErrorGain,
        output upperLimit, lowerLimit,
        input  integrator
    );

    modport filter (
        input  setpoint, invertError, zeroError, posErrorGain, negErrorGain,
        input  upperLimit, lowerLimit,
        output integrator
    );

endinterface

// ==== logic/agcLoopRegs.sv ====
// AGC loop registers
`timescale 1ns/1ps

module agcLoopRegs import agcTypesPkg::*, agcRegMapPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cs,
    input  logic       wr0,
    input  logic       wr1,
    input  logic       wr2,
    input  logic       wr3,
    input  regAddr_t   addr,
    input  busWord_t   din,
    output busWord_t   dout,
    output blockLen_t  blockLen,
    agcCtrlIf.regs     ctrl
);

    busWord_t   ctrlReg;
    loopWord_t  upperReg;
    loopWord_t  lowerReg;
    blockLen_t  blockReg;
    logic [3:0] wrEn;

    // replaces the bytes selected by strobe and keeps the rest.
    function automatic busWord_t mergeBytes(input busWord_t current, input busWord_t data,
                                            input logic [3:0] strobe);
        busWord_t merged;
        merged = current;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign wrEn = {wr3, wr2, wr1, wr0} & {4{cs}};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg  <= ctrlReset;
            upperReg <= upperReset;
            lowerReg <= lowerReset;
            blockReg <= blockLenReset;
        end else begin
            case (addr)
                ctrlAddr:  ctrlReg  <= mergeBytes(ctrlReg, din, wrEn) & ctrlMask;
                upperAddr: upperReg <= mergeBytes(upperReg, din, wrEn);
                lowerAddr: lowerReg <= mergeBytes(lowerReg, din, wrEn);
                blockAddr: begin
                    if (wrEn[0]) begin
                        blockReg <= din[7:0]; // only the low byte is implemented.
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                ctrlAddr:       dout = ctrlReg;
                upperAddr:      dout = upperReg;
                lowerAddr:      dout = lowerReg;
                integratorAddr: dout = ctrl.integrator;
                blockAddr:      dout = {24'b0, blockReg};
                default:        dout = '0;
            endcase
        end
    end

    assign ctrl.setpoint     = ctrlReg[setpointLsb +: $bits(level_t)];
    assign ctrl.invertError  = ctrlReg[invertBit];
    assign ctrl.zeroError    = ctrlReg[zeroBit];
    assign ctrl.posErrorGain = ctrlReg[posGainLsb +: $bits(shift_t)];
    assign ctrl.negErrorGain = ctrlReg[negGainLsb +: $bits(shift_t)];
    assign ctrl.upperLimit   = upperReg;
    assign ctrl.lowerLimit   = lowerReg;
    assign blockLen          = blockReg;

    idleBusReadsZero: assert property (@(posedge clk) disable iff (reset) !cs |-> dout == '0);

endmodule

// ==== logic/agcLevelDetector.sv ====
// AGC block peak detector
`timescale 1ns/1ps

module agcLevelDetector import agcTypesPkg::*; #(
    parameter int SampleWidth = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [SampleWidth-1:0] sample,
    input  logic                          sampleValid,
    input  blockLen_t                     blockLen,
    output level_t                        signalLevel,
    output logic                          levelValid
);

    logic [SampleWidth-1:0] magnitude;
    level_t                 sampleLevel;
    level_t                 peak;
    level_t                 blockPeak;
    blockLen_t              sampleCount; // valid samples already taken in this block.
    blockLen_t              effLen;
    logic                   blockEnd;

    always_comb begin
        magnitude = sample[SampleWidth-1] ? -sample : sample;
        if (magnitude[SampleWidth-1]) begin
            magnitude = {1'b0, {(SampleWidth-1){1'b1}}}; // the most negative sample clips.
        end
        sampleLevel = magnitude[SampleWidth-2 -: 8];
    end

    assign effLen    = (blockLen == '0) ? 8'd1 : blockLen; // zero length acts as one.
    assign blockPeak = (sampleLevel > peak) ? sampleLevel : peak;
    assign blockEnd  = sampleValid && (({1'b0, sampleCount} + 9'd1) >= {1'b0, effLen});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            peak        <= '0;
            sampleCount <= '0;
            signalLevel <= '0;
            levelValid  <= 1'b0;
        end else begin
            levelValid <= blockEnd;
            if (blockEnd) begin
                signalLevel <= blockPeak;
                peak        <= '0;            // the next block starts from silence.
                sampleCount <= '0;
            end else if (sampleValid) begin
                peak        <= blockPeak;
                sampleCount <= sampleCount + 8'd1;
            end
        end
    end

    singleCycleStrobe: assert property (@(posedge clk) disable iff (reset)
        levelValid && (blockLen > 8'd1) |=> !levelValid);

endmodule

// ==== logic/agcLoopFilter.sv ====
// AGC loop filter
`timescale 1ns/1ps

module agcLoopFilter import agcTypesPkg::*, agcRegMapPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      clkEn,
    input  level_t    signalLevel,
    agcCtrlIf.filter  ctrl,
    output loopWord_t loopOutput
);

    logic               enLead;     // loopError holds a fresh value.
    logic               enInteg;    // leadError holds a fresh value.
    logic signed [8:0]  fwdError;
    logic signed [8:0]  revError;
    logic signed [7:0]  loopError;
    shift_t             leadShift;
    logic signed [31:0] errorExt;
    logic signed [31:0] leadError;
    logic signed [32:0] sum;
    loopWord_t          integrator;

    // Each stage fires on its own delayed strobe so overlapping updates stay ordered.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enLead  <= 1'b0;
            enInteg <= 1'b0;
        end else begin
            enLead  <= clkEn;
            enInteg <= enLead;
        end
    end

    assign fwdError = $signed({1'b0, ctrl.setpoint}) - $signed({1'b0, signalLevel});
    assign revError = $signed({1'b0, signalLevel}) - $signed({1'b0, ctrl.setpoint});

    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (ctrl.zeroError) begin
                loopError <= '0;
            end else if (ctrl.invertError) begin
                loopError <= revError[8:1];   // halved to fit eight bits.
            end else begin
                loopError <= fwdError[8:1];
            end
        end
    end

    assign leadShift = loopError[7] ? ctrl.negErrorGain : ctrl.posErrorGain;
    assign errorExt  = 32'(loopError);          // sign extended.

    always_ff @(posedge clk) begin
        if (enLead) begin
            if (leadShift >= 5'd7) begin
                leadError <= errorExt <<< (leadShift - 5'd7);
            end else begin
                leadError <= errorExt >>> (5'd7 - leadShift); // shifts below 7 attenuate.
            end
        end
    end

    assign sum = $signed({1'b0, integrator}) + $signed({leadError[31], leadError});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            integrator <= integratorReset;
        end else if (enInteg) begin
            if (leadError[31] && sum[32]) begin
                integrator <= ctrl.lowerLimit;      // wrapped below zero.
            end else if (!leadError[31] && sum[32]) begin
                integrator <= ctrl.upperLimit;      // carried past the top.
            end else if (sum[31:0] >= ctrl.upperLimit) begin
                integrator <= ctrl.upperLimit;
            end else if (sum[31:0] <= ctrl.lowerLimit) begin
                integrator <= ctrl.lowerLimit;
            end else begin
                integrator <= sum[31:0];
            end
        end
    end

    assign loopOutput      = integrator;
    assign ctrl.integrator = integrator;

    integratorInLimits: assert property (@(posedge clk) disable iff (reset)
        enInteg && (ctrl.lowerLimit < ctrl.upperLimit) |=>
        (integrator >= $past(ctrl.lowerLimit)) && (integrator <= $past(ctrl.upperLimit)));

endmodule

// ==== logic/agcGainStage.sv ====
// AGC gain stage
`timescale 1ns/1ps

module agcGainStage import agcTypesPkg::*; #(
    parameter int SampleWidth = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [SampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    input  loopWord_t                     gain,
    output logic signed [SampleWidth-1:0] gainedOut,
    output logic                          outValid
);

    localparam int ProdWidth   = SampleWidth + 17;
    localparam int ScaledWidth = ProdWidth - 12;
    localparam logic signed [SampleWidth-1:0] MaxSample = {1'b0, {(SampleWidth-1){1'b1}}};
    localparam logic signed [SampleWidth-1:0] MinSample = {1'b1, {(SampleWidth-1){1'b0}}};

    logic signed [ProdWidth-1:0]   product;
    logic signed [ScaledWidth-1:0] scaled;
    logic signed [SampleWidth-1:0] saturated;

    // gain bits 31..16 are an unsigned multiplier where 4096 is unity.
    assign product = sampleIn * $signed({1'b0, gain[31:16]});
    assign scaled  = product[ProdWidth-1:12]; // dropping bits floors toward minus infinity.

    always_comb begin
        if (scaled > MaxSample) begin
            saturated = MaxSample;
        end else if (scaled < MinSample) begin
            saturated = MinSample;
        end else begin
            saturated = scaled[SampleWidth-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sampleValid;
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            gainedOut <= saturated;
        end
    end

    validFollowsInput: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> outValid == $past(sampleValid));

endmodule

// ==== logic/agcTop.sv ====
// AGC subsystem top
`timescale 1ns/1ps

module agcTop import agcTypesPkg::*; #(
    parameter int SampleWidth = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cs,
    input  logic                          wr0,
    input  logic                          wr1,
    input  logic                          wr2,
    input  logic                          wr3,
    input  regAddr_t                      addr,
    input  busWord_t                      din,
    output busWord_t                      dout,
    input  logic signed [SampleWidth-1:0] sampleIn,
    input  logic                          sampleValid,
    output logic signed [SampleWidth-1:0] gainedOut,
    output logic                          outValid,
    output level_t                        signalLevel,
    output logic                          levelValid,
    output loopWord_t                     gainOut
);

    blockLen_t blockLen;

    agcCtrlIf ctrlBus ();

    agcLoopRegs loopRegs (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .blockLen(blockLen),
        .ctrl(ctrlBus.regs)
    );

    agcGainStage #(.SampleWidth(SampleWidth)) gainStage (
        .clk(clk), .reset(reset),
        .sampleIn(sampleIn), .sampleValid(sampleValid),
        .gain(gainOut),                     // closes the loop back to the datapath.
        .gainedOut(gainedOut), .outValid(outValid)
    );

    agcLevelDetector #(.SampleWidth(SampleWidth)) levelDetector (
        .clk(clk), .reset(reset),
        .sample(gainedOut), .sampleValid(outValid),
        .blockLen(blockLen),
        .signalLevel(signalLevel), .levelValid(levelValid)
    );

    agcLoopFilter loopFilter (
        .clk(clk), .reset(reset),
        .clkEn(levelValid),                 // one update per measured block.
        .signalLevel(signalLevel),
        .ctrl(ctrlBus.filter),
        .loopOutput(gainOut)
    );

endmodule

// ==== tb/agcTb.sv ====
// AGC subsystem testbench
`timescale 1ns/1ps

module agcTb import agcTypesPkg::*, agcRegMapPkg::*; ();

    localparam int SampleWidth = 16;
    localparam int Timeout     = 2000; // cycles allowed for the pipeline to drain.

    logic                          clk;
    logic                          reset;
    logic                          cs;
    logic                          wr0;
    logic                          wr1;
    logic                          wr2;
    logic                          wr3;
    regAddr_t                      addr;
    busWord_t                      din;
    busWord_t                      dout;
    logic signed [SampleWidth-1:0] sampleIn;
    logic                          sampleValid;
    logic signed [SampleWidth-1:0] gainedOut;
    logic                          outValid;
    level_t                        signalLevel;
    logic                          levelValid;
    loopWord_t                     gainOut;

    integer    seed = 56;
    int        cycle = 0;
    level_t    setpoint = 8'h40;     // copies of the programmed loop settings.
    logic      invertError = 1'b0;
    logic      zeroError = 1'b0;
    shift_t    posShift = 5'd8;
    shift_t    negShift = 5'd8;
    loopWord_t upperLimit = 32'h4000_0000;
    loopWord_t lowerLimit = 32'h0100_0000;
    blockLen_t blockLen = 8'd16;
    loopWord_t modelInteg = 32'h1000_0000;   // after the latest update in flight.
    loopWord_t visibleInteg = 32'h1000_0000; // what gainOut shows this cycle.
    int        dueCycle[$];
    loopWord_t dueValue[$];
    logic      gainDue = 1'b0;
    int        expGained = 0;
    logic      levelDue = 1'b0;
    level_t    expLevel = '0;
    level_t    peak = '0;
    int        count = 0;
    loopWord_t held;

    agcTop #(.SampleWidth(SampleWidth)) uut (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .sampleIn(sampleIn), .sampleValid(sampleValid),
        .gainedOut(gainedOut), .outValid(outValid),
        .signalLevel(signalLevel), .levelValid(levelValid),
        .gainOut(gainOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic checkEq(input string what, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // gain bits 31..16 with 12 fraction bits, floored and saturated.
    function automatic int gainModel(input int sample, input loopWord_t gain);
        longint scaled;
        longint maxOut;
        maxOut = (longint'(1) <<< (SampleWidth - 1)) - 1;
        scaled = (longint'(sample) * longint'(gain[31:16])) >>> 12;
        if (scaled > maxOut) return int'(maxOut);
        if (scaled < -maxOut - 1) return int'(-maxOut - 1);
        return int'(scaled);
    endfunction

    function automatic level_t levelOf(input int sample);
        int magnitude;
        int maxMagnitude;
        maxMagnitude = (1 <<< (SampleWidth - 1)) - 1;
        magnitude = (sample < 0) ? -sample : sample;
        if (magnitude > maxMagnitude) begin
            magnitude = maxMagnitude; // only the most negative sample lands here.
        end
        return level_t'(magnitude >>> (SampleWidth - 9));
    endfunction

    function automatic int effectiveLen();
        return (blockLen == 8'd0) ? 1 : int'(blockLen);
    endfunction

    // next integrator value for one measured level.
    function automatic loopWord_t nextIntegrator(input level_t level, input loopWord_t current);
        int     diff;
        int     err;
        int     shift;
        longint lead;
        longint total;
        if (zeroError) diff = 0;
        else if (invertError) diff = int'(level) - int'(setpoint);
        else diff = int'(setpoint) - int'(level);
        err = diff >>> 1;
        shift = (err < 0) ? int'(negShift) : int'(posShift);
        if (shift >= 7) lead = longint'(err) <<< (shift - 7);
        else lead = longint'(err) >>> (7 - shift);
        lead = longint'(int'(lead[31:0]));   // the lead error is a 32-bit word.
        total = longint'(current) + lead;
        if (total < 0) return lowerLimit;
        if (total >= (longint'(1) <<< 32)) return upperLimit;
        if (total >= longint'(upperLimit)) return upperLimit;
        if (total <= longint'(lowerLimit)) return lowerLimit;
        return loopWord_t'(total);
    endfunction

    task automatic writeReg(input regAddr_t a, input busWord_t data, input logic [3:0] strobe);
        @(posedge clk);
        #2;
        cs   = 1'b1;
        addr = a;
        din  = data;
        {wr3, wr2, wr1, wr0} = strobe;
        @(posedge clk);
        #2;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic readCheck(input regAddr_t a, input busWord_t expected, input string what);
        @(posedge clk);
        #2;
        cs   = 1'b1;
        addr = a;
        @(negedge clk);
        checkEq(what, 64'(dout), 64'(expected));
        @(posedge clk);
        #2;
        cs = 1'b0;
    endtask

    task automatic setCtrl(input level_t sp, input logic inv, input logic zero,
                           input shift_t pos, input shift_t neg);
        writeReg(ctrlAddr, {3'b0, neg, 3'b0, pos, 6'b0, zero, inv, sp}, 4'b1111);
        setpoint    = sp;
        invertError = inv;
        zeroError   = zero;
        posShift    = pos;
        negShift    = neg;
    endtask

    task automatic setLimits(input loopWord_t upper, input loopWord_t lower);
        writeReg(upperAddr, upper, 4'b1111);
        writeReg(lowerAddr, lower, 4'b1111);
        upperLimit = upper;
        lowerLimit = lower;
    endtask

    task automatic setBlockLen(input blockLen_t len);
        writeReg(blockAddr, {24'b0, len}, 4'b0001);
        blockLen = len;
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > Timeout) begin
                $display("Timed out waiting for the AGC pipeline to drain");
                $display("STATUS: FAIL");
                $fatal(1, "drain timeout");
            end
        end while (gainDue || levelDue || count != 0 || dueCycle.size() != 0);
    endtask

    // whole blocks of random samples with random gaps in sampleValid.
    task automatic sendBlocks(input int blocks, input int amplitude);
        int total;
        int sent;
        total = blocks * effectiveLen();
        sent  = 0;
        while (sent < total) begin
            @(posedge clk);
            #2;
            sampleValid = (($random(seed) & 3) != 0);
            sampleIn    = SampleWidth'($random(seed) % (amplitude + 1));
            if (sampleValid) sent++;
        end
        @(posedge clk);
        #2;
        sampleValid = 1'b0;
        waitIdle();
    endtask

    initial begin : compareOutputs
        forever begin
            @(negedge clk);
            if (!reset) begin
                cycle++;
                if (dueCycle.size() != 0 && dueCycle[0] == cycle) begin
                    void'(dueCycle.pop_front());
                    visibleInteg = dueValue.pop_front();
                end
                checkEq("gainOut", 64'(gainOut), 64'(visibleInteg));
                checkEq("levelValid", 64'(levelValid), 64'(levelDue));
                if (levelValid) begin
                    checkEq("signalLevel", 64'(signalLevel), 64'(expLevel));
                    modelInteg = nextIntegrator(expLevel, modelInteg);
                    dueCycle.push_back(cycle + 3); // integrator lands three cycles later.
                    dueValue.push_back(modelInteg);
                end
                levelDue = 1'b0;
                checkEq("outValid", 64'(outValid), 64'(gainDue));
                if (outValid) begin
                    checkEq("gainedOut", 64'(gainedOut), 64'(expGained));
                    if (levelOf(expGained) > peak) peak = levelOf(expGained);
                    count++;
                    if (count >= effectiveLen()) begin
                        expLevel = peak;
                        levelDue = 1'b1;
                        peak     = '0;
                        count    = 0;
                    end
                end
                gainDue = 1'b0;
                if (sampleValid) begin
                    expGained = gainModel(int'(sampleIn), visibleInteg);
                    gainDue   = 1'b1;
                end
            end
        end
    end

    initial begin : runTests
        reset       = 1'b1;
        cs          = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr        = '0;
        din         = '0;
        sampleIn    = '0;
        sampleValid = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        readCheck(ctrlAddr, 32'h0808_0040, "ctrl reset value");
        readCheck(upperAddr, 32'h4000_0000, "upper limit reset value");
        readCheck(lowerAddr, 32'h0100_0000, "lower limit reset value");
        readCheck(integratorAddr, 32'h1000_0000, "integrator reset value");
        readCheck(blockAddr, 32'd16, "block length reset value");
        readCheck(13'h100, 32'd0, "unmapped address");
        writeReg(upperAddr, 32'hAABB_CCDD, 4'b0010);
        readCheck(upperAddr, 32'h4000_CC00, "upper limit byte 1 write");
        writeReg(upperAddr, 32'hAABB_CCDD, 4'b1000);
        readCheck(upperAddr, 32'hAA00_CC00, "upper limit byte 3 write");
        writeReg(ctrlAddr, 32'h1122_3355, 4'b0001);
        readCheck(ctrlAddr, 32'h0808_0055, "ctrl byte 0 write");
        setCtrl(8'h40, 1'b0, 1'b0, 5'd8, 5'd8);
        setLimits(32'h4000_0000, 32'h0100_0000);

        sendBlocks(3, 32767);                  // unity gain, blocks of 16.
        setBlockLen(8'd1);
        sendBlocks(20, 20000);
        setBlockLen(8'd0);                     // acts as a length of one.
        sendBlocks(10, 8000);
        setBlockLen(8'd5);
        sendBlocks(6, 32767);

        // loud input gives negative errors, attenuated by the small shift.
        setCtrl(8'h60, 1'b0, 1'b0, 5'd16, 5'd3);
        sendBlocks(6, 30000);
        // inverted, so loud input gives positive errors on the small shift.
        setCtrl(8'h20, 1'b1, 1'b0, 5'd4, 5'd12);
        sendBlocks(6, 30000);
        setCtrl(8'h60, 1'b0, 1'b1, 5'd16, 5'd16);
        held = visibleInteg;
        sendBlocks(4, 30000);
        checkEq("integrator held with zero error", 64'(gainOut), 64'(held));

        // quiet input with a high setpoint pushes the gain up to four.
        setBlockLen(8'd4);
        setCtrl(8'hFF, 1'b0, 1'b0, 5'd26, 5'd8);
        sendBlocks(16, 100);
        checkEq("gain at upper limit", 64'(gainOut), 64'(32'h4000_0000));
        sendBlocks(4, 32767);                  // outputs saturate at this gain.
        readCheck(integratorAddr, visibleInteg, "integrator readback");

        setLimits(visibleInteg + 32'h0010_0000, visibleInteg - 32'h0010_0000);
        setCtrl(8'hFF, 1'b0, 1'b0, 5'd24, 5'd24);
        sendBlocks(2, 0);
        checkEq("clamp to upper limit", 64'(gainOut), 64'(upperLimit));
        setCtrl(8'h00, 1'b0, 1'b0, 5'd24, 5'd24);
        sendBlocks(2, 32767);
        checkEq("clamp to lower limit", 64'(gainOut), 64'(lowerLimit));
        readCheck(integratorAddr, lowerLimit, "integrator readback at lower limit");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
logic/agcTypesPkg.sv
logic/agcRegMapPkg.sv
logic/agcCtrlIf.sv
logic/agcLoopRegs.sv
logic/agcLevelDetector.sv
logic/agcLoopFilter.sv
logic/agcGainStage.sv
logic/agcTop.sv
tb/agcTb.sv

// ==== Makefile ====
# Verilator lint and simulation of the AGC subsystem.

VERILATOR ?= verilator
TOP       ?= agcTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
